// File: hw/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// reorder buffer entries
// a power of two so tags wrap on their own
`define ROB_DEPTH 16

// tag width, log2 of ROB_DEPTH
`define TAG_W 4

// data and address width
`define XLEN 32

// architectural registers
`define REG_COUNT 32

// retired stores waiting for memory
`define STQ_DEPTH 4

`endif

// File: hw/isa_pkg.sv
`include "backend_config.svh"

package isa_pkg;

    // register or store data word
    typedef logic [`XLEN-1:0] data_t;

    // byte address or program counter
    typedef logic [`XLEN-1:0] addr_t;

    // architectural register name
    // x0 is hardwired to zero
    typedef logic [$clog2(`REG_COUNT)-1:0] regnm_t;

    // how an entry leaves the reorder buffer
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        LOAD   = 2'd1,
        STORE  = 2'd2,
        BRANCH = 2'd3
    } op_class_t;

endpackage

// File: hw/rob_pkg.sv
`include "backend_config.svh"

package rob_pkg;

    // reorder buffer slot naming an in-flight result
    typedef logic [`TAG_W-1:0] tag_t;

    // lifetime of one slot
    // FREE     not allocated
    // WAITING  allocated, result not back yet
    // DONE     result recorded, may retire
    typedef enum logic [1:0] {
        FREE    = 2'd0,
        WAITING = 2'd1,
        DONE    = 2'd2
    } entry_state_t;

endpackage

// File: hw/rob.sv
`timescale 1ns/10ps
`include "backend_config.svh"

module rob (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  alloc_en,
    input  isa_pkg::regnm_t       alloc_regnm,
    input  isa_pkg::op_class_t    alloc_class,
    input  logic                  alloc_pred_taken,
    output logic                  alloc_ready,
    output rob_pkg::tag_t         alloc_tag,

    output logic                  rename_en,
    output isa_pkg::regnm_t       rename_regnm,
    output rob_pkg::tag_t         rename_tag,

    input  logic                  ex_en,
    input  rob_pkg::tag_t         ex_tag,
    input  isa_pkg::data_t        ex_data,
    input  logic                  ex_taken,
    input  isa_pkg::addr_t        ex_target,

    input  logic                  lsu_en,
    input  rob_pkg::tag_t         lsu_tag,
    input  isa_pkg::data_t        lsu_data,
    input  isa_pkg::addr_t        lsu_addr,

    input  logic                  stq_full,

    output logic                  commit_en,
    output isa_pkg::regnm_t       commit_regnm,
    output isa_pkg::data_t        commit_data,
    output rob_pkg::tag_t         commit_tag,

    output logic                  store_en,
    output isa_pkg::addr_t        store_addr,
    output isa_pkg::data_t        store_data,

    output logic                  flush_en,
    output isa_pkg::addr_t        redirect_pc
);

    localparam int COUNT_W = `TAG_W + 1;

    rob_pkg::entry_state_t ent_state [`ROB_DEPTH];
    isa_pkg::regnm_t       ent_regnm [`ROB_DEPTH];
    isa_pkg::op_class_t    ent_class [`ROB_DEPTH];
    logic                  ent_pred  [`ROB_DEPTH];
    logic                  ent_taken [`ROB_DEPTH];
    isa_pkg::data_t        ent_data  [`ROB_DEPTH];
    // store address or branch target
    isa_pkg::addr_t        ent_addr  [`ROB_DEPTH];

    rob_pkg::tag_t         head;
    rob_pkg::tag_t         tail;
    logic [COUNT_W-1:0]    count;

    logic                  do_alloc;
    logic                  hit_ex;
    logic                  hit_lsu;
    logic                  head_done;
    logic                  head_taken;
    isa_pkg::data_t        head_data;
    isa_pkg::addr_t        head_addr;
    logic                  retire_store;
    logic                  retire_flush;
    logic                  retire_commit;
    logic                  do_retire;

    assign alloc_ready  = (count != COUNT_W'(`ROB_DEPTH));
    assign alloc_tag    = tail;
    assign do_alloc     = alloc_en && alloc_ready;

    // x0 never gets a producer
    assign rename_en    = do_alloc && (alloc_regnm != '0);
    assign rename_regnm = alloc_regnm;
    assign rename_tag   = tail;

    // a head completing this cycle retires at the same edge
    assign hit_ex  = ex_en && (ex_tag == head);
    assign hit_lsu = lsu_en && (lsu_tag == head);
    assign head_done = (ent_state[head] == rob_pkg::DONE) ||
                       ((ent_state[head] == rob_pkg::WAITING) && (hit_ex || hit_lsu));

    always_comb begin
        head_data  = ent_data[head];
        head_addr  = ent_addr[head];
        head_taken = ent_taken[head];
        if (hit_ex) begin
            head_data  = ex_data;
            head_addr  = ex_target;
            head_taken = ex_taken;
        end else if (hit_lsu) begin
            head_data = lsu_data;
            head_addr = lsu_addr;
        end
    end

    assign retire_store  = head_done && (ent_class[head] == isa_pkg::STORE) && !stq_full;
    assign retire_flush  = head_done && (ent_class[head] == isa_pkg::BRANCH) &&
                           (head_taken != ent_pred[head]);
    assign retire_commit = head_done && (ent_class[head] != isa_pkg::STORE) && !retire_flush;
    assign do_retire     = retire_store || retire_commit;

    always_ff @(posedge clk) begin
        if (rst || retire_flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ent_state[i] <= rob_pkg::FREE;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_alloc) begin
                ent_state[tail] <= rob_pkg::WAITING;
                tail            <= tail + 1'b1;
            end
            if (ex_en && (ent_state[ex_tag] == rob_pkg::WAITING)) begin
                ent_state[ex_tag] <= rob_pkg::DONE;
            end
            if (lsu_en && (ent_state[lsu_tag] == rob_pkg::WAITING)) begin
                ent_state[lsu_tag] <= rob_pkg::DONE;
            end
            // freeing the head overrides a completion at the same slot
            if (do_retire) begin
                ent_state[head] <= rob_pkg::FREE;
                head            <= head + 1'b1;
            end
            count <= count + COUNT_W'(do_alloc) - COUNT_W'(do_retire);
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_regnm[tail] <= alloc_regnm;
            ent_class[tail] <= alloc_class;
            ent_pred[tail]  <= alloc_pred_taken;
        end
        if (ex_en) begin
            ent_data[ex_tag]  <= ex_data;
            ent_taken[ex_tag] <= ex_taken;
            ent_addr[ex_tag]  <= ex_target;
        end
        if (lsu_en) begin
            ent_data[lsu_tag] <= lsu_data;
            ent_addr[lsu_tag] <= lsu_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_en <= 1'b0;
            store_en  <= 1'b0;
            flush_en  <= 1'b0;
        end else begin
            commit_en <= retire_commit;
            store_en  <= retire_store;
            flush_en  <= retire_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_commit) begin
            commit_regnm <= ent_regnm[head];
            commit_data  <= head_data;
            commit_tag   <= head;
        end
        if (retire_store) begin
            store_addr <= head_addr;
            store_data <= head_data;
        end
        if (retire_flush) begin
            redirect_pc <= head_addr;
        end
    end

endmodule

// File: hw/reg_status_file.sv
`timescale 1ns/10ps
`include "backend_config.svh"

module reg_status_file (
    input  logic             clk,
    input  logic             rst,

    input  logic             rename_en,
    input  isa_pkg::regnm_t  rename_regnm,
    input  rob_pkg::tag_t    rename_tag,

    input  logic             commit_en,
    input  isa_pkg::regnm_t  commit_regnm,
    input  isa_pkg::data_t   commit_data,
    input  rob_pkg::tag_t    commit_tag,

    input  logic             flush_en,

    input  isa_pkg::regnm_t  rs1_regnm,
    input  isa_pkg::regnm_t  rs2_regnm,
    output isa_pkg::data_t   rs1_value,
    output logic             rs1_busy,
    output rob_pkg::tag_t    rs1_tag,
    output isa_pkg::data_t   rs2_value,
    output logic             rs2_busy,
    output rob_pkg::tag_t    rs2_tag
);

    isa_pkg::data_t          regs     [`REG_COUNT];
    rob_pkg::tag_t           prod_tag [`REG_COUNT];
    logic [`REG_COUNT-1:0]   busy;

    always_ff @(posedge clk) begin
        if (commit_en && (commit_regnm != '0)) begin
            regs[commit_regnm] <= commit_data;
        end
        if (rename_en) begin
            prod_tag[rename_regnm] <= rename_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (flush_en) begin
                busy <= '0;
            end else if (commit_en && (prod_tag[commit_regnm] == commit_tag)) begin
                // only the newest producer releases the register
                busy[commit_regnm] <= 1'b0;
            end
            // a new rename wins over retire and flush
            if (rename_en && (rename_regnm != '0)) begin
                busy[rename_regnm] <= 1'b1;
            end
        end
    end

    assign rs1_value = (rs1_regnm == '0) ? '0 : regs[rs1_regnm];
    assign rs1_busy  = busy[rs1_regnm];
    assign rs1_tag   = prod_tag[rs1_regnm];

    assign rs2_value = (rs2_regnm == '0) ? '0 : regs[rs2_regnm];
    assign rs2_busy  = busy[rs2_regnm];
    assign rs2_tag   = prod_tag[rs2_regnm];

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/10ps
`include "backend_config.svh"

module store_buffer (
    input  logic            clk,
    input  logic            rst,

    input  logic            store_en,
    input  isa_pkg::addr_t  store_addr,
    input  isa_pkg::data_t  store_data,

    output logic            stq_full,

    output logic            mem_we,
    output isa_pkg::addr_t  mem_addr,
    output isa_pkg::data_t  mem_data,
    input  logic            mem_ready
);

    localparam int PTR_W = $clog2(`STQ_DEPTH);
    localparam int CNT_W = $clog2(`STQ_DEPTH + 1);

    isa_pkg::addr_t    q_addr [`STQ_DEPTH];
    isa_pkg::data_t    q_data [`STQ_DEPTH];

    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    // oldest store sits on the port until memory takes it
    assign mem_we   = (count != '0);
    assign mem_addr = q_addr[rd_ptr];
    assign mem_data = q_data[rd_ptr];
    assign pop      = mem_we && mem_ready;

    // a store already on its way from the rob holds a slot too
    assign stq_full = ((count + CNT_W'(store_en)) >= CNT_W'(`STQ_DEPTH));

    always_ff @(posedge clk) begin
        if (store_en) begin
            q_addr[wr_ptr] <= store_addr;
            q_data[wr_ptr] <= store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (store_en) begin
                if (wr_ptr == PTR_W'(`STQ_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(`STQ_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            count <= count + CNT_W'(store_en) - CNT_W'(pop);
        end
    end

endmodule

// File: hw/backend_top.sv
`timescale 1ns/10ps

module backend_top (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 alloc_en,
    input  isa_pkg::regnm_t      alloc_regnm,
    input  isa_pkg::op_class_t   alloc_class,
    input  logic                 alloc_pred_taken,
    output logic                 alloc_ready,
    output rob_pkg::tag_t        alloc_tag,

    input  logic                 ex_en,
    input  rob_pkg::tag_t        ex_tag,
    input  isa_pkg::data_t       ex_data,
    input  logic                 ex_taken,
    input  isa_pkg::addr_t       ex_target,

    input  logic                 lsu_en,
    input  rob_pkg::tag_t        lsu_tag,
    input  isa_pkg::data_t       lsu_data,
    input  isa_pkg::addr_t       lsu_addr,

    input  isa_pkg::regnm_t      rs1_regnm,
    input  isa_pkg::regnm_t      rs2_regnm,
    output isa_pkg::data_t       rs1_value,
    output logic                 rs1_busy,
    output rob_pkg::tag_t        rs1_tag,
    output isa_pkg::data_t       rs2_value,
    output logic                 rs2_busy,
    output rob_pkg::tag_t        rs2_tag,

    output logic                 commit_en,
    output isa_pkg::regnm_t      commit_regnm,
    output isa_pkg::data_t       commit_data,
    output rob_pkg::tag_t        commit_tag,

    output logic                 flush_en,
    output isa_pkg::addr_t       redirect_pc,

    output logic                 mem_we,
    output isa_pkg::addr_t       mem_addr,
    output isa_pkg::data_t       mem_data,
    input  logic                 mem_ready
);

    logic             rename_en;
    isa_pkg::regnm_t  rename_regnm;
    rob_pkg::tag_t    rename_tag;
    logic             store_en;
    isa_pkg::addr_t   store_addr;
    isa_pkg::data_t   store_data;
    logic             stq_full;

    rob rob0 (
        .clk, .rst,
        .alloc_en, .alloc_regnm, .alloc_class, .alloc_pred_taken,
        .alloc_ready, .alloc_tag,
        .rename_en, .rename_regnm, .rename_tag,
        .ex_en, .ex_tag, .ex_data, .ex_taken, .ex_target,
        .lsu_en, .lsu_tag, .lsu_data, .lsu_addr,
        .stq_full,
        .commit_en, .commit_regnm, .commit_data, .commit_tag,
        .store_en, .store_addr, .store_data,
        .flush_en, .redirect_pc
    );

    reg_status_file rsf0 (
        .clk, .rst,
        .rename_en, .rename_regnm, .rename_tag,
        .commit_en, .commit_regnm, .commit_data, .commit_tag,
        .flush_en,
        .rs1_regnm, .rs2_regnm,
        .rs1_value, .rs1_busy, .rs1_tag,
        .rs2_value, .rs2_busy, .rs2_tag
    );

    // retired stores are architectural, so no flush here
    store_buffer stb0 (
        .clk, .rst,
        .store_en, .store_addr, .store_data,
        .stq_full,
        .mem_we, .mem_addr, .mem_data, .mem_ready
    );

endmodule

// File: verification/backend_properties.sv
`timescale 1ns/10ps
`include "backend_config.svh"

module backend_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  alloc_en,
    input logic                  alloc_ready,
    input logic                  commit_en,
    input logic                  store_en,
    input logic                  flush_en,
    input rob_pkg::entry_state_t ent_state [`ROB_DEPTH]
);

    logic all_free;

    always_comb begin
        all_free = 1'b1;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (ent_state[i] != rob_pkg::FREE) begin
                all_free = 1'b0;
            end
        end
    end

    one_retire_pulse: assert property (@(posedge clk) disable iff (rst)
        $onehot0({commit_en, store_en, flush_en}))
        else $error("commit, store and flush pulses overlap");

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> alloc_ready)
        else $error("allocation while the reorder buffer is full");

    // flush pulse is high in the cycle after the clearing edge
    flush_clears_all: assert property (@(posedge clk) disable iff (rst)
        flush_en |-> all_free)
        else $error("entries left allocated after a flush");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(commit_en || store_en || flush_en))
        else $error("retirement outputs active after reset");

endmodule

bind rob backend_properties props0 (
    .clk, .rst, .alloc_en, .alloc_ready, .commit_en, .store_en, .flush_en, .ent_state
);

// File: verification/backend_tb.sv
`timescale 1ns/10ps
`include "backend_config.svh"

module backend_tb;

    // six tests of at most about 100 cycles each
    localparam int MAX_CYCLES = 6 * 100;

    logic clk, rst;
    logic alloc_en, alloc_pred_taken, alloc_ready;
    logic ex_en, ex_taken, lsu_en;
    logic rs1_busy, rs2_busy, commit_en, flush_en, mem_we, mem_ready;
    isa_pkg::regnm_t alloc_regnm, rs1_regnm, rs2_regnm, commit_regnm;
    isa_pkg::op_class_t alloc_class;
    rob_pkg::tag_t alloc_tag, ex_tag, lsu_tag, rs1_tag, rs2_tag, commit_tag;
    isa_pkg::data_t ex_data, lsu_data, rs1_value, rs2_value, commit_data, mem_data;
    isa_pkg::addr_t ex_target, lsu_addr, redirect_pc, mem_addr;

    int errors = 0;
    int cycles = 0;

    backend_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_data(input string name, input isa_pkg::data_t exp,
                              input isa_pkg::data_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input isa_pkg::addr_t exp,
                              input isa_pkg::addr_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_pkg::tag_t exp,
                             input rob_pkg::tag_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_regnm(input string name, input isa_pkg::regnm_t exp,
                               input isa_pkg::regnm_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected x%0d got x%0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report(input string name, input int start);
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    // drivers start and end just after a falling edge
    task automatic alloc(input isa_pkg::regnm_t rd, input isa_pkg::op_class_t cls,
                         input logic pred, output rob_pkg::tag_t tag);
        alloc_en = 1'b1;
        alloc_regnm = rd;
        alloc_class = cls;
        alloc_pred_taken = pred;
        tag = alloc_tag;
        @(negedge clk);
        alloc_en = 1'b0;
    endtask

    task automatic ex_done(input rob_pkg::tag_t tag, input isa_pkg::data_t d,
                           input logic taken, input isa_pkg::addr_t target);
        ex_en = 1'b1;
        ex_tag = tag;
        ex_data = d;
        ex_taken = taken;
        ex_target = target;
        @(negedge clk);
        ex_en = 1'b0;
    endtask

    task automatic lsu_done(input rob_pkg::tag_t tag, input isa_pkg::data_t d,
                            input isa_pkg::addr_t a);
        lsu_en = 1'b1;
        lsu_tag = tag;
        lsu_data = d;
        lsu_addr = a;
        @(negedge clk);
        lsu_en = 1'b0;
    endtask

    task automatic test_alloc();
        int start;
        rob_pkg::tag_t t;
        start = errors;
        check_bit("alloc_ready", 1'b1, alloc_ready);
        check_bit("commit_en", 1'b0, commit_en);
        check_bit("flush_en", 1'b0, flush_en);
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            alloc(isa_pkg::regnm_t'(i + 1), isa_pkg::ALU, 1'b0, t);
            check_tag("alloc_tag", rob_pkg::tag_t'(i), t);
        end
        check_bit("alloc_ready", 1'b0, alloc_ready);
        report("allocation", start);
    endtask

    task automatic test_inorder();
        int start;
        int j;
        int tmp;
        int order [$];
        isa_pkg::data_t d [`ROB_DEPTH];
        start = errors;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            d[i] = $urandom;
            if (i > 0) begin
                order.push_back(i);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // head held back so nothing retires yet
        foreach (order[k]) begin
            ex_done(rob_pkg::tag_t'(order[k]), d[order[k]], 1'b0, '0);
            check_bit("commit_en", 1'b0, commit_en);
        end
        ex_done('0, d[0], 1'b0, '0);
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            check_bit("commit_en", 1'b1, commit_en);
            check_tag("commit_tag", rob_pkg::tag_t'(i), commit_tag);
            check_regnm("commit_regnm", isa_pkg::regnm_t'(i + 1), commit_regnm);
            check_data("commit_data", d[i], commit_data);
            if (i == 0) begin
                check_bit("alloc_ready", 1'b1, alloc_ready);
            end
            @(negedge clk);
        end
        check_bit("commit_en", 1'b0, commit_en);
        report("in-order retirement", start);
    endtask

    task automatic test_rename();
        int start;
        rob_pkg::tag_t ta, tb, tz;
        isa_pkg::data_t d1, d2;
        start = errors;
        d1 = $urandom;
        d2 = $urandom;
        rs1_regnm = 5;
        rs2_regnm = 0;
        alloc(5, isa_pkg::ALU, 1'b0, ta);
        check_bit("rs1_busy", 1'b1, rs1_busy);
        check_tag("rs1_tag", ta, rs1_tag);
        alloc(5, isa_pkg::ALU, 1'b0, tb);
        check_tag("rs1_tag", tb, rs1_tag);
        alloc(0, isa_pkg::ALU, 1'b0, tz);
        check_bit("rs2_busy", 1'b0, rs2_busy);
        ex_done(ta, d1, 1'b0, '0);
        rs2_regnm = 5;
        ex_done(tb, d2, 1'b0, '0);
        // older producer wrote x5 but the younger one still owns it
        check_data("rs1_value", d1, rs1_value);
        check_bit("rs1_busy", 1'b1, rs1_busy);
        check_tag("rs1_tag", tb, rs1_tag);
        check_data("rs2_value", d1, rs2_value);
        check_bit("rs2_busy", 1'b1, rs2_busy);
        check_tag("rs2_tag", tb, rs2_tag);
        rs2_regnm = 0;
        ex_done(tz, $urandom, 1'b0, '0);
        check_data("rs1_value", d2, rs1_value);
        check_bit("rs1_busy", 1'b0, rs1_busy);
        @(negedge clk);
        check_data("rs2_value", '0, rs2_value);
        check_bit("rs2_busy", 1'b0, rs2_busy);
        report("rename status", start);
    endtask

    task automatic test_stores();
        int start;
        int n;
        int got;
        logic seen;
        rob_pkg::tag_t st [5];
        rob_pkg::tag_t ta;
        isa_pkg::addr_t a [5];
        isa_pkg::data_t d [5];
        isa_pkg::data_t dv;
        start = errors;
        mem_ready = 1'b0;
        dv = $urandom;
        for (int i = 0; i < 5; i++) begin
            a[i] = isa_pkg::addr_t'($urandom) & ~32'h3;
            d[i] = $urandom;
            alloc(0, isa_pkg::STORE, 1'b0, st[i]);
        end
        alloc(7, isa_pkg::ALU, 1'b0, ta);
        for (int i = 0; i < 5; i++) begin
            lsu_done(st[i], d[i], a[i]);
        end
        ex_done(ta, dv, 1'b0, '0);
        // fifth store and the ALU wait on a full queue
        repeat (8) begin
            check_bit("commit_en", 1'b0, commit_en);
            check_bit("mem_we", 1'b1, mem_we);
            check_addr("mem_addr", a[0], mem_addr);
            check_data("mem_data", d[0], mem_data);
            @(negedge clk);
        end
        n = 0;
        got = 0;
        seen = 1'b0;
        while ((got < 5 || !seen) && n < 80) begin
            if (commit_en) begin
                check_regnm("commit_regnm", 7, commit_regnm);
                check_data("commit_data", dv, commit_data);
                seen = 1'b1;
            end
            mem_ready = 1'($urandom);
            if (mem_we && mem_ready) begin
                if (got < 5) begin
                    check_addr("mem_addr", a[got], mem_addr);
                    check_data("mem_data", d[got], mem_data);
                end
                got++;
            end
            @(negedge clk);
            n++;
        end
        mem_ready = 1'b0;
        if (got != 5 || !seen) begin
            $display("error at %0t: stores did not drain or the ALU never retired", $time);
            errors++;
        end
        report("stores", start);
    endtask

    task automatic test_mispredict();
        int start;
        rob_pkg::tag_t ts, tbr, ty;
        isa_pkg::addr_t sa, target;
        isa_pkg::data_t sd;
        start = errors;
        sa = isa_pkg::addr_t'($urandom) & ~32'h3;
        sd = $urandom;
        target = isa_pkg::addr_t'($urandom) & ~32'h3;
        rs1_regnm = 9;
        alloc(0, isa_pkg::STORE, 1'b0, ts);
        alloc(0, isa_pkg::BRANCH, 1'b0, tbr);
        alloc(9, isa_pkg::ALU, 1'b0, ty);
        ex_done(ty, $urandom, 1'b0, '0);
        check_bit("rs1_busy", 1'b1, rs1_busy);
        lsu_done(ts, sd, sa);
        ex_done(tbr, '0, 1'b1, target);
        check_bit("flush_en", 1'b1, flush_en);
        check_addr("redirect_pc", target, redirect_pc);
        check_bit("commit_en", 1'b0, commit_en);
        check_tag("alloc_tag", '0, alloc_tag);
        @(negedge clk);
        check_bit("rs1_busy", 1'b0, rs1_busy);
        check_bit("flush_en", 1'b0, flush_en);
        repeat (3) begin
            check_bit("commit_en", 1'b0, commit_en);
            @(negedge clk);
        end
        // store retired before the branch still goes out
        check_bit("mem_we", 1'b1, mem_we);
        check_addr("mem_addr", sa, mem_addr);
        check_data("mem_data", sd, mem_data);
        mem_ready = 1'b1;
        @(negedge clk);
        mem_ready = 1'b0;
        check_bit("mem_we", 1'b0, mem_we);
        report("misprediction", start);
    endtask

    task automatic test_predict_ok();
        int start;
        rob_pkg::tag_t tbr, ta;
        isa_pkg::data_t dv;
        start = errors;
        dv = $urandom;
        alloc(0, isa_pkg::BRANCH, 1'b1, tbr);
        alloc(11, isa_pkg::ALU, 1'b0, ta);
        ex_done(ta, dv, 1'b0, '0);
        ex_done(tbr, '0, 1'b1, 32'h0000_0200);
        check_bit("commit_en", 1'b1, commit_en);
        check_tag("commit_tag", tbr, commit_tag);
        check_bit("flush_en", 1'b0, flush_en);
        @(negedge clk);
        check_bit("commit_en", 1'b1, commit_en);
        check_tag("commit_tag", ta, commit_tag);
        check_regnm("commit_regnm", 11, commit_regnm);
        check_data("commit_data", dv, commit_data);
        check_bit("flush_en", 1'b0, flush_en);
        @(negedge clk);
        check_bit("commit_en", 1'b0, commit_en);
        report("correct prediction", start);
    endtask

    initial begin
        void'($urandom(32'he108_3844));
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc_regnm = '0;
        alloc_class = isa_pkg::ALU;
        alloc_pred_taken = 1'b0;
        ex_en = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        lsu_en = 1'b0;
        lsu_tag = '0;
        lsu_data = '0;
        lsu_addr = '0;
        rs1_regnm = '0;
        rs2_regnm = '0;
        mem_ready = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_alloc();
        test_inorder();
        test_rename();
        test_stores();
        test_mispredict();
        test_predict_ok();
        $display("finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob.sv
hw/reg_status_file.sv
hw/store_buffer.sv
hw/backend_top.sv
verification/backend_properties.sv
verification/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module backend_tb \
    -f sources.f --Mdir obj_dir -o backend_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/backend_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
